/* Bender.yml */
package:
  name: issue_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/issue_pkg.sv
      - verilog/gpr_file.sv
      - verilog/scoreboard.sv
      - verilog/issue.sv
      - verilog/commit.sv
      - verilog/issue_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_issue_stage.sv

/* bench/tb_issue_stage.sv */
`include "issue_cfg.svh"

module tb_issue_stage
  import issue_pkg::*;
();

  localparam int PERIOD    = 100;
  localparam int WB_PORTS  = `ISSUE_WB_PORTS;
  localparam int N_LOADS   = 31;
  localparam int N_INDEP   = 16;
  localparam int N_CHAIN   = 32;
  localparam int N_MIX     = 64;
  localparam int N_FILL    = 16;
  localparam int N_FLUSH   = 9;
  localparam int N_ZERO    = 12;
  localparam int TOTAL     = N_LOADS + N_INDEP + N_CHAIN + N_MIX + N_FILL + N_FLUSH + N_ZERO;
  localparam int MAX_LAT   = 6;
  localparam int WATCHDOG  = (TOTAL * MAX_LAT * `ISSUE_SB_DEPTH + 100) * PERIOD;

  // a load flag stands in for a load unit that hands back a chosen value
  typedef struct packed {
    decoder_t               instr;
    logic                   load;
    logic [`ISSUE_XLEN-1:0] value;
  } stim_t;

  typedef struct packed {
    decoder_t               instr;
    logic [`ISSUE_XLEN-1:0] wdata;
  } retire_t;

  typedef struct packed {
    trans_id_t              id;
    logic [`ISSUE_XLEN-1:0] data;
    int                     delay;
  } job_t;

  logic                             clock;
  logic                             arst_n;
  decoder_t                         idu2isu_instr;
  logic                             idu_valid;
  logic                             isu2idu_ready;
  logic                             flush_unissued_instr;
  fu_data_t                         fu_data;
  logic                             alu_valid;
  logic                             mdu_valid;
  logic                             alu_ready;
  logic                             mdu_ready;
  writeback_t [WB_PORTS-1:0]        wb;
  logic                             retire_valid;
  logic [`ISSUE_XLEN-1:0]           retire_pc;
  logic [4:0]                       retire_rd;
  logic [`ISSUE_XLEN-1:0]           retire_wdata;
  logic                             retire_is_rv16;

  stim_t                  stim_q [$];
  stim_t                  held_q [$];
  retire_t                retire_q [$];
  job_t                   job_q [$];
  logic [`ISSUE_XLEN-1:0] ref_regs [32];
  logic [31:0]            rng_state = 32'he731_34af;
  logic [`ISSUE_XLEN-1:0] next_pc = 32'h0000_1000;
  string                  test_name = "reset";
  int                     dispatch_count = 0;
  logic                   random_ready = 1'b1;
  logic                   force_mdu_low = 1'b0;
  logic                   long_mdu = 1'b0;
  logic                   flush_req = 1'b0;
  logic                   ready_low_seen = 1'b0;

  issue_stage uut (.*);

  initial begin
    clock = 1'b0;
    forever #(PERIOD / 2) clock = ~clock;
  end

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic logic [`ISSUE_XLEN-1:0] operate(input fu_op_e op,
      input logic [`ISSUE_XLEN-1:0] a, input logic [`ISSUE_XLEN-1:0] b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_XOR: return a ^ b;
      ALU_AND: return a & b;
      default: return a * b;  // lower half of the product
    endcase
  endfunction

  // runs in program order, so ref_regs always holds the architectural state seen by s
  function automatic logic [`ISSUE_XLEN-1:0] reference_exec(input stim_t s,
      output logic [`ISSUE_XLEN-1:0] a, output logic [`ISSUE_XLEN-1:0] b);
    logic [`ISSUE_XLEN-1:0] result;
    a = ref_regs[s.instr.rs1];
    b = ref_regs[s.instr.rs2];
    result = s.load ? s.value : operate(s.instr.op, a, b);
    if (s.instr.rd != 5'd0) ref_regs[s.instr.rd] = result;
    return result;
  endfunction

  function automatic int pick_latency(input fu_e fu);
    if (fu == FU_MDU) return long_mdu ? MAX_LAT : 1 + int'(next_random() % 6);
    return 1 + int'(next_random() % 2);
  endfunction

  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic compare_dispatch(input string name, input fu_data_t exp, input fu_data_t act);
    if (exp !== act) begin
      $write("ERROR %s dispatch: expected op %0d a %h b %h id %0d, ", name, exp.op,
             exp.operand_a, exp.operand_b, exp.trans_id);
      $display("actual op %0d a %h b %h id %0d", act.op, act.operand_a, act.operand_b,
               act.trans_id);
      abort_run();
    end
  endtask

  task automatic compare_retire(input string name, input decoder_t exp_instr,
      input logic [`ISSUE_XLEN-1:0] exp_wdata, input logic [`ISSUE_XLEN-1:0] act_pc,
      input logic [4:0] act_rd, input logic [`ISSUE_XLEN-1:0] act_wdata, input logic act_rv16);
    if (exp_instr.pc !== act_pc || exp_instr.rd !== act_rd || exp_wdata !== act_wdata ||
        exp_instr.is_rv16 !== act_rv16) begin
      $write("ERROR %s retire: expected pc %h rd %0d wdata %h rv16 %b, ", name,
             exp_instr.pc, exp_instr.rd, exp_wdata, exp_instr.is_rv16);
      $display("actual pc %h rd %0d wdata %h rv16 %b", act_pc, act_rd, act_wdata, act_rv16);
      abort_run();
    end
  endtask

  task automatic push_instr(input fu_op_e op, input logic [4:0] rs1, input logic [4:0] rs2,
      input logic [4:0] rd, input logic load, input logic [`ISSUE_XLEN-1:0] value);
    stim_t s;
    s.instr.fu      = (op == MDU_MUL) ? FU_MDU : FU_ALU;
    s.instr.op      = op;
    s.instr.rs1     = rs1;
    s.instr.rs2     = rs2;
    s.instr.rd      = rd;
    s.instr.pc      = next_pc;
    s.instr.is_rv16 = 1'(next_random() % 2);
    s.load          = load;
    s.value         = value;
    next_pc = next_pc + (s.instr.is_rv16 ? 2 : 4);
    stim_q.push_back(s);
  endtask

  task automatic wait_idle();
    @(negedge clock);
    while (stim_q.size() != 0 || held_q.size() != 0 || retire_q.size() != 0 ||
           job_q.size() != 0) begin
      @(negedge clock);
    end
  endtask

  // sampled at the rising edge, before any register of the DUT moves
  always @(posedge clock) begin
    stim_t                  s;
    fu_data_t               exp_fu;
    logic [`ISSUE_XLEN-1:0] exp_a;
    logic [`ISSUE_XLEN-1:0] exp_b;
    logic [`ISSUE_XLEN-1:0] result;
    logic                   dispatched;
    if (arst_n) begin
      if ((alu_valid && !alu_ready) || (mdu_valid && !mdu_ready) || (alu_valid && mdu_valid)) begin
        $display("%s: a unit valid strobe was raised without a legal dispatch", test_name);
        abort_run();
      end
      dispatched = alu_valid || mdu_valid;
      if (!isu2idu_ready) ready_low_seen = 1'b1;
      if (retire_valid) begin
        if (retire_q.size() == 0) begin
          $display("%s: an instruction retired that was never dispatched", test_name);
          abort_run();
        end
        compare_retire(test_name, retire_q[0].instr, retire_q[0].wdata, retire_pc, retire_rd,
                       retire_wdata, retire_is_rv16);
        void'(retire_q.pop_front());
      end
      if (dispatched) begin
        if (held_q.size() == 0) begin
          $display("%s: a dispatch happened with no accepted instruction", test_name);
          abort_run();
        end
        s = held_q.pop_front();
        if (mdu_valid != (s.instr.fu == FU_MDU)) begin
          $display("%s: instruction at pc %h went to the wrong unit", test_name, s.instr.pc);
          abort_run();
        end
        result = reference_exec(s, exp_a, exp_b);
        exp_fu = '{op: s.instr.op, operand_a: exp_a, operand_b: exp_b,
                   trans_id: trans_id_t'(dispatch_count)};
        compare_dispatch(test_name, exp_fu, fu_data);
        retire_q.push_back('{instr: s.instr, wdata: result});
        job_q.push_back('{id: fu_data.trans_id,
                          data: s.load ? s.value
                                       : operate(fu_data.op, fu_data.operand_a, fu_data.operand_b),
                          delay: pick_latency(s.instr.fu)});
        dispatch_count++;
      end else if (flush_unissued_instr && held_q.size() != 0) begin
        void'(held_q.pop_front());
      end
      if (idu_valid && isu2idu_ready) begin
        s = stim_q.pop_front();
        // a flush without a dispatch also drops whatever arrives in that cycle
        if (dispatched || !flush_unissued_instr) held_q.push_back(s);
      end
    end
  end

  // the functional units and the decode side are driven a little after each rising edge
  always begin
    int port;
    int first;
    int i;
    int k;
    @(posedge clock);
    #10;
    if (arst_n) begin
      wb = '0;
      for (i = 0; i < job_q.size(); i++) begin
        if (job_q[i].delay > 0) job_q[i].delay = job_q[i].delay - 1;
      end
      i = 0;
      while (i < job_q.size()) begin
        port = -1;
        if (job_q[i].delay == 0) begin
          first = int'(next_random() % WB_PORTS);
          for (k = 0; k < WB_PORTS; k++) begin
            if (port < 0 && !wb[(first + k) % WB_PORTS].valid) port = (first + k) % WB_PORTS;
          end
        end
        if (port >= 0) begin
          wb[port] = '{valid: 1'b1, trans_id: job_q[i].id, data: job_q[i].data};
          job_q.delete(i);
        end else begin
          i++;
        end
      end
      alu_ready = random_ready ? (next_random() % 4 != 0) : 1'b1;
      mdu_ready = force_mdu_low ? 1'b0 : random_ready ? (next_random() % 4 != 0) : 1'b1;
      flush_unissued_instr = flush_req;
      idu_valid = stim_q.size() != 0 && !flush_req && (next_random() % 8 != 0);
      if (stim_q.size() != 0) idu2isu_instr = stim_q[0].instr;
    end
  end

  initial begin
    #(WATCHDOG);
    $display("watchdog expired in test %s before the run finished", test_name);
    abort_run();
  end

  task automatic independent_ops();
    test_name = "independent";
    for (int r = 1; r <= N_LOADS; r++) push_instr(ALU_ADD, 5'd0, 5'd0, 5'(r), 1'b1, next_random());
    for (int n = 0; n < N_INDEP; n++) begin
      push_instr(fu_op_e'(next_random() % 4), 5'(1 + next_random() % 15),
                 5'(1 + next_random() % 15), 5'(16 + n), 1'b0, '0);
    end
    wait_idle();
  endtask

  task automatic raw_chains();
    logic [4:0] rd;
    test_name = "raw_chains";
    rd = 5'd1;
    for (int n = 0; n < N_CHAIN; n++) begin
      push_instr(fu_op_e'(next_random() % 5), rd, (n % 3 == 0) ? 5'(1 + next_random() % 8) : rd,
                 5'(1 + next_random() % 8), 1'b0, '0);
      rd = stim_q[$].instr.rd;  // next one reads what this one writes
    end
    wait_idle();
  endtask

  task automatic mixed_units();
    test_name = "mixed_units";
    for (int n = 0; n < N_MIX; n++) begin
      push_instr(fu_op_e'(next_random() % 5), 5'(next_random()), 5'(next_random()),
                 5'(1 + next_random() % 31), 1'b0, '0);
    end
    wait_idle();
  endtask

  task automatic fill_scoreboard();
    test_name = "scoreboard_full";
    random_ready   = 1'b0;
    long_mdu       = 1'b1;
    ready_low_seen = 1'b0;
    for (int n = 0; n < N_FILL; n++) begin
      push_instr(MDU_MUL, 5'(1 + n % 8), 5'(9 + n % 8), 5'(17 + n % 8), 1'b0, '0);
    end
    wait_idle();
    long_mdu     = 1'b0;
    random_ready = 1'b1;
    if (!ready_low_seen) begin
      $display("%s: decode ready never fell although the scoreboard should have filled",
               test_name);
      abort_run();
    end
  endtask

  task automatic flush_held();
    test_name = "flush";
    force_mdu_low = 1'b1;
    push_instr(MDU_MUL, 5'd3, 5'd4, 5'd5, 1'b0, '0);
    while (held_q.size() == 0) @(negedge clock);
    flush_req = 1'b1;
    @(posedge clock);
    @(negedge clock);
    flush_req = 1'b0;
    @(negedge clock);
    // the MDU is still held off, so ready can only be high if the holding register emptied
    if (!isu2idu_ready) begin
      $display("%s: the held instruction was not dropped by the flush", test_name);
      abort_run();
    end
    force_mdu_low = 1'b0;
    for (int n = 1; n < N_FLUSH; n++) begin
      push_instr(fu_op_e'(next_random() % 5), 5'(5), 5'(next_random()),
                 5'(1 + next_random() % 31), 1'b0, '0);
    end
    wait_idle();
  endtask

  task automatic zero_dest();
    test_name = "x0_dest";
    for (int n = 0; n < N_ZERO / 2; n++) begin
      push_instr(fu_op_e'(next_random() % 5), 5'(1 + next_random() % 31),
                 5'(1 + next_random() % 31), 5'd0, 1'b0, '0);
    end
    for (int n = 0; n < N_ZERO / 2; n++) begin
      push_instr(fu_op_e'(next_random() % 5), (n % 2 == 0) ? 5'd0 : 5'(1 + n),
                 (n % 2 == 0) ? 5'(1 + n) : 5'd0, 5'(20 + n), 1'b0, '0);
    end
    wait_idle();
  endtask

  initial begin
    arst_n               = 1'b0;
    idu2isu_instr        = '0;
    idu_valid            = 1'b0;
    flush_unissued_instr = 1'b0;
    alu_ready            = 1'b0;
    mdu_ready            = 1'b0;
    wb                   = '0;
    for (int r = 0; r < 32; r++) ref_regs[r] = '0;
    repeat (10) @(posedge clock);
    #20 arst_n = 1'b1;
    @(negedge clock);
    if (!isu2idu_ready || alu_valid || mdu_valid || retire_valid) begin
      $display("outputs are not in their reset state after reset");
      abort_run();
    end
    independent_ops();
    raw_chains();
    mixed_units();
    fill_scoreboard();
    flush_held();
    zero_dest();
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* src.f */
+incdir+verilog
verilog/issue_pkg.sv
verilog/gpr_file.sv
verilog/scoreboard.sv
verilog/issue.sv
verilog/commit.sv
verilog/issue_stage.sv
bench/tb_issue_stage.sv

/* verilog/commit.sv */
`include "issue_cfg.svh"

module commit
  import issue_pkg::*;
(
  input  logic                   head_valid,
  input  logic                   head_done,
  input  decoder_t               head_instr,
  input  logic [`ISSUE_XLEN-1:0] head_result,
  output logic                   pop,

  output logic                   gpr_we,
  output logic [4:0]             gpr_waddr,
  output logic [`ISSUE_XLEN-1:0] gpr_wdata,

  output logic                   retire_valid,
  output logic [`ISSUE_XLEN-1:0] retire_pc,
  output logic [4:0]             retire_rd,
  output logic [`ISSUE_XLEN-1:0] retire_wdata,
  output logic                   retire_is_rv16
);

  logic retire;

  // only the oldest entry may leave, so retirement stays in program order
  assign retire = head_valid && head_done;
  assign pop    = retire;

  // x0 still retires and reports its value, it just never lands in the file
  assign gpr_we    = retire && head_instr.rd != 5'd0;
  assign gpr_waddr = head_instr.rd;
  assign gpr_wdata = head_result;

  assign retire_valid   = retire;
  assign retire_pc      = head_instr.pc;
  assign retire_rd      = head_instr.rd;
  assign retire_wdata   = head_result;
  assign retire_is_rv16 = head_instr.is_rv16;

endmodule

/* verilog/gpr_file.sv */
`include "issue_cfg.svh"

module gpr_file (
  input  logic                   clock,
  input  logic                   arst_n,
  input  logic [4:0]             gpr_raddr_a,
  input  logic [4:0]             gpr_raddr_b,
  output logic [`ISSUE_XLEN-1:0] gpr_rdata_a,
  output logic [`ISSUE_XLEN-1:0] gpr_rdata_b,
  input  logic                   gpr_we,
  input  logic [4:0]             gpr_waddr,
  input  logic [`ISSUE_XLEN-1:0] gpr_wdata
);

  // x0 has no storage, it is hardwired to zero on the read side
  logic [`ISSUE_XLEN-1:0] regs [1:31];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (gpr_we && gpr_waddr != 5'd0) begin
      regs[gpr_waddr] <= gpr_wdata;
    end
  end

  // same-cycle writes are not bypassed here, the scoreboard still holds that value
  assign gpr_rdata_a = (gpr_raddr_a == 5'd0) ? '0 : regs[gpr_raddr_a];
  assign gpr_rdata_b = (gpr_raddr_b == 5'd0) ? '0 : regs[gpr_raddr_b];

endmodule

/* verilog/issue.sv */
`include "issue_cfg.svh"

module issue
  import issue_pkg::*;
(
  input  logic                   clock,
  input  logic                   arst_n,

  input  decoder_t               idu2isu_instr,
  input  logic                   idu_valid,
  output logic                   isu2idu_ready,
  input  logic                   flush_unissued_instr,

  output fu_data_t               fu_data,
  output logic                   alu_valid,
  output logic                   mdu_valid,
  input  logic                   alu_ready,
  input  logic                   mdu_ready,

  output logic                   alloc_valid,
  output decoder_t               alloc_instr,
  input  trans_id_t              alloc_id,
  input  logic                   sb_full,

  output logic [4:0]             rs1_addr,
  output logic [4:0]             rs2_addr,
  input  logic                   rs1_busy,
  input  logic                   rs1_done,
  input  logic                   rs2_busy,
  input  logic                   rs2_done,
  input  logic [`ISSUE_XLEN-1:0] rs1_fwd,
  input  logic [`ISSUE_XLEN-1:0] rs2_fwd,

  output logic [4:0]             gpr_raddr_a,
  output logic [4:0]             gpr_raddr_b,
  input  logic [`ISSUE_XLEN-1:0] gpr_rdata_a,
  input  logic [`ISSUE_XLEN-1:0] gpr_rdata_b
);

  decoder_t               instr_q;
  logic                   valid_q;
  logic [`ISSUE_XLEN-1:0] operand_a;
  logic [`ISSUE_XLEN-1:0] operand_b;
  logic                   operands_ready;
  logic                   unit_ready;
  logic                   dispatch;
  logic                   accept;

  assign rs1_addr    = instr_q.rs1;
  assign rs2_addr    = instr_q.rs2;
  assign gpr_raddr_a = instr_q.rs1;
  assign gpr_raddr_b = instr_q.rs2;

  // an in-flight writer means the register file copy is stale
  assign operand_a = rs1_busy ? rs1_fwd : gpr_rdata_a;
  assign operand_b = rs2_busy ? rs2_fwd : gpr_rdata_b;

  assign operands_ready = !(rs1_busy && !rs1_done) && !(rs2_busy && !rs2_done);
  assign unit_ready     = (instr_q.fu == FU_MDU) ? mdu_ready : alu_ready;

  assign dispatch  = valid_q && operands_ready && unit_ready && !sb_full;
  assign alu_valid = dispatch && instr_q.fu == FU_ALU;
  assign mdu_valid = dispatch && instr_q.fu == FU_MDU;

  // the entry is allocated in the same cycle the unit takes the instruction
  assign alloc_valid = dispatch;
  assign alloc_instr = instr_q;

  assign fu_data = '{op: instr_q.op, operand_a: operand_a, operand_b: operand_b,
                     trans_id: alloc_id};

  assign isu2idu_ready = !valid_q || dispatch;
  assign accept        = idu_valid && isu2idu_ready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else if (dispatch) begin
      valid_q <= accept;  // dispatch beats a flush in the same cycle
    end else if (flush_unissued_instr) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      instr_q <= idu2isu_instr;
    end
  end

endmodule

/* verilog/issue_cfg.svh */
`ifndef ISSUE_CFG_SVH
`define ISSUE_CFG_SVH

// width of data words and of the pc
`define ISSUE_XLEN 32

// in-flight entries, any power of two from 2 to 16
`define ISSUE_SB_DEPTH 4

// result ports coming back from the functional units
`define ISSUE_WB_PORTS 2

`endif

/* verilog/issue_pkg.sv */
`include "issue_cfg.svh"

package issue_pkg;

  // index into the scoreboard, also used as the transaction id
  typedef logic [$clog2(`ISSUE_SB_DEPTH)-1:0] trans_id_t;

  typedef enum logic {
    FU_ALU,
    FU_MDU
  } fu_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_AND,
    MDU_MUL
  } fu_op_e;

  typedef struct packed {
    fu_e                    fu;
    fu_op_e                 op;
    logic [4:0]             rs1;
    logic [4:0]             rs2;
    logic [4:0]             rd;
    logic [`ISSUE_XLEN-1:0] pc;
    logic                   is_rv16;
  } decoder_t;

  typedef struct packed {
    fu_op_e                 op;
    logic [`ISSUE_XLEN-1:0] operand_a;
    logic [`ISSUE_XLEN-1:0] operand_b;
    trans_id_t              trans_id;
  } fu_data_t;

  typedef struct packed {
    logic                   valid;
    trans_id_t              trans_id;
    logic [`ISSUE_XLEN-1:0] data;
  } writeback_t;

endpackage

/* verilog/issue_stage.sv */
`include "issue_cfg.svh"

module issue_stage
  import issue_pkg::*;
(
  input  logic                             clock,
  input  logic                             arst_n,

  input  decoder_t                         idu2isu_instr,
  input  logic                             idu_valid,
  output logic                             isu2idu_ready,
  input  logic                             flush_unissued_instr,

  output fu_data_t                         fu_data,
  output logic                             alu_valid,
  output logic                             mdu_valid,
  input  logic                             alu_ready,
  input  logic                             mdu_ready,

  input  writeback_t [`ISSUE_WB_PORTS-1:0] wb,

  output logic                             retire_valid,
  output logic [`ISSUE_XLEN-1:0]           retire_pc,
  output logic [4:0]                       retire_rd,
  output logic [`ISSUE_XLEN-1:0]           retire_wdata,
  output logic                             retire_is_rv16
);

  logic                   alloc_valid;
  decoder_t               alloc_instr;
  trans_id_t              alloc_id;
  logic                   sb_full;

  logic [4:0]             rs1_addr;
  logic [4:0]             rs2_addr;
  logic                   rs1_busy;
  logic                   rs1_done;
  logic [`ISSUE_XLEN-1:0] rs1_fwd;
  logic                   rs2_busy;
  logic                   rs2_done;
  logic [`ISSUE_XLEN-1:0] rs2_fwd;

  logic [4:0]             gpr_raddr_a;
  logic [4:0]             gpr_raddr_b;
  logic [`ISSUE_XLEN-1:0] gpr_rdata_a;
  logic [`ISSUE_XLEN-1:0] gpr_rdata_b;
  logic                   gpr_we;
  logic [4:0]             gpr_waddr;
  logic [`ISSUE_XLEN-1:0] gpr_wdata;

  logic                   head_valid;
  logic                   head_done;
  decoder_t               head_instr;
  logic [`ISSUE_XLEN-1:0] head_result;
  logic                   pop;

  issue issue_unit (
    .clock                (clock),
    .arst_n               (arst_n),
    .idu2isu_instr        (idu2isu_instr),
    .idu_valid            (idu_valid),
    .isu2idu_ready        (isu2idu_ready),
    .flush_unissued_instr (flush_unissued_instr),
    .fu_data              (fu_data),
    .alu_valid            (alu_valid),
    .mdu_valid            (mdu_valid),
    .alu_ready            (alu_ready),
    .mdu_ready            (mdu_ready),
    .alloc_valid          (alloc_valid),
    .alloc_instr          (alloc_instr),
    .alloc_id             (alloc_id),
    .sb_full              (sb_full),
    .rs1_addr             (rs1_addr),
    .rs2_addr             (rs2_addr),
    .rs1_busy             (rs1_busy),
    .rs1_done             (rs1_done),
    .rs2_busy             (rs2_busy),
    .rs2_done             (rs2_done),
    .rs1_fwd              (rs1_fwd),
    .rs2_fwd              (rs2_fwd),
    .gpr_raddr_a          (gpr_raddr_a),
    .gpr_raddr_b          (gpr_raddr_b),
    .gpr_rdata_a          (gpr_rdata_a),
    .gpr_rdata_b          (gpr_rdata_b)
  );

  scoreboard scoreboard_unit (
    .clock       (clock),
    .arst_n      (arst_n),
    .alloc_valid (alloc_valid),
    .alloc_instr (alloc_instr),
    .alloc_id    (alloc_id),
    .sb_full     (sb_full),
    .wb          (wb),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_busy    (rs1_busy),
    .rs1_done    (rs1_done),
    .rs1_fwd     (rs1_fwd),
    .rs2_busy    (rs2_busy),
    .rs2_done    (rs2_done),
    .rs2_fwd     (rs2_fwd),
    .head_valid  (head_valid),
    .head_done   (head_done),
    .head_instr  (head_instr),
    .head_result (head_result),
    .pop         (pop)
  );

  commit commit_unit (
    .head_valid     (head_valid),
    .head_done      (head_done),
    .head_instr     (head_instr),
    .head_result    (head_result),
    .pop            (pop),
    .gpr_we         (gpr_we),
    .gpr_waddr      (gpr_waddr),
    .gpr_wdata      (gpr_wdata),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_wdata   (retire_wdata),
    .retire_is_rv16 (retire_is_rv16)
  );

  gpr_file gpr_unit (
    .clock       (clock),
    .arst_n      (arst_n),
    .gpr_raddr_a (gpr_raddr_a),
    .gpr_raddr_b (gpr_raddr_b),
    .gpr_rdata_a (gpr_rdata_a),
    .gpr_rdata_b (gpr_rdata_b),
    .gpr_we      (gpr_we),
    .gpr_waddr   (gpr_waddr),
    .gpr_wdata   (gpr_wdata)
  );

endmodule

/* verilog/scoreboard.sv */
`include "issue_cfg.svh"

module scoreboard
  import issue_pkg::*;
(
  input  logic                                   clock,
  input  logic                                   arst_n,

  input  logic                                   alloc_valid,
  input  decoder_t                               alloc_instr,
  output trans_id_t                              alloc_id,
  output logic                                   sb_full,

  input  writeback_t [`ISSUE_WB_PORTS-1:0]       wb,

  input  logic [4:0]                             rs1_addr,
  input  logic [4:0]                             rs2_addr,
  output logic                                   rs1_busy,
  output logic                                   rs1_done,
  output logic [`ISSUE_XLEN-1:0]                 rs1_fwd,
  output logic                                   rs2_busy,
  output logic                                   rs2_done,
  output logic [`ISSUE_XLEN-1:0]                 rs2_fwd,

  output logic                                   head_valid,
  output logic                                   head_done,
  output decoder_t                               head_instr,
  output logic [`ISSUE_XLEN-1:0]                 head_result,
  input  logic                                   pop
);

  localparam int depth = `ISSUE_SB_DEPTH;
  localparam int cnt_w = $clog2(depth) + 1;

  logic [depth-1:0]       valid_q;
  logic [depth-1:0]       done_q;
  decoder_t               instr_q  [depth];
  logic [`ISSUE_XLEN-1:0] result_q [depth];

  trans_id_t              head_q;
  trans_id_t              tail_q;
  logic [cnt_w-1:0]       count_q;

  assign alloc_id = tail_q;  // new entries always go to the tail
  assign sb_full  = (count_q == cnt_w'(depth));

  assign head_valid  = valid_q[head_q];
  assign head_done   = done_q[head_q];
  assign head_instr  = instr_q[head_q];
  assign head_result = result_q[head_q];

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
      done_q  <= '0;
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (alloc_valid) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;  // pointer wraps on its own
      end
      if (pop) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      // the units only report ids that are outstanding, never the slot being allocated
      for (int p = 0; p < `ISSUE_WB_PORTS; p++) begin
        if (wb[p].valid) begin
          done_q[wb[p].trans_id] <= 1'b1;
        end
      end
      count_q <= count_q + cnt_w'(alloc_valid) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_valid) begin
      instr_q[tail_q] <= alloc_instr;
    end
    for (int p = 0; p < `ISSUE_WB_PORTS; p++) begin
      if (wb[p].valid) begin
        result_q[wb[p].trans_id] <= wb[p].data;
      end
    end
  end

  // walk from head to tail so the youngest writer of the register is the one left standing
  function automatic void lookup(
    input  logic [4:0]             addr,
    output logic                   busy,
    output logic                   done,
    output logic [`ISSUE_XLEN-1:0] fwd
  );
    trans_id_t idx;
    busy = 1'b0;
    done = 1'b0;
    fwd  = '0;
    for (int i = 0; i < depth; i++) begin
      idx = head_q + trans_id_t'(i);
      if (valid_q[idx] && instr_q[idx].rd == addr && addr != 5'd0) begin
        busy = 1'b1;
        done = done_q[idx];
        fwd  = result_q[idx];
      end
    end
  endfunction

  always_comb begin
    lookup(rs1_addr, rs1_busy, rs1_done, rs1_fwd);
    lookup(rs2_addr, rs2_busy, rs2_done, rs2_fwd);
  end

endmodule
